/* fpss.f */
logic/fpss_pkg.sv
logic/fpss_decoder.sv
logic/fpss_regfile.sv
logic/fpss_controller.sv
logic/fpss_exec.sv
logic/fpss_top.sv
dv/fpss_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f fpss.f --top-module fpss_tb

sim:
	verilator --binary --timing --assert -f fpss.f --top-module fpss_tb -o fpss_sim
	./obj_dir/fpss_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* dv/fpss_tb.sv */
`timescale 1ns/1ps

module fpss_tb;

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_TXN      = 500;
  localparam int DRAIN_CYCLES = 100;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  x_issue_valid_i;
  logic                  x_issue_ready_o;
  fpss_pkg::issue_req_t  x_issue_req_i;
  fpss_pkg::issue_resp_t x_issue_resp_o;
  logic                  x_result_valid_o;
  logic                  x_result_ready_i;
  fpss_pkg::result_t     x_result_o;

  // Reference model state
  logic [31:0]                   rng_q;
  logic [fpss_pkg::XLEN-1:0]     model_fpr [fpss_pkg::NUM_FPR];
  fpss_pkg::result_t             exp_q [$];
  fpss_pkg::result_t             held_res;
  logic                          hold_res;
  logic                          hold_req;
  int                            issued;
  int                            results;
  int                            checks;
  int                            errors;
  int                            drain;

  fpss_top dut0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .x_issue_valid_i  (x_issue_valid_i),
    .x_issue_ready_o  (x_issue_ready_o),
    .x_issue_req_i    (x_issue_req_i),
    .x_issue_resp_o   (x_issue_resp_o),
    .x_result_valid_o (x_result_valid_o),
    .x_result_ready_i (x_result_ready_i),
    .x_result_o       (x_result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_q;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_q = x;
    return x;
  endfunction

  // Half the picks land in f0..f3 so dependencies are frequent
  function automatic logic [4:0] pick_reg();
    logic [31:0] r;
    logic [4:0]  sel;
    r = next_rand();
    if (r[8]) begin
      sel = {3'b000, r[1:0]};
    end else begin
      sel = r[4:0];
    end
    return sel;
  endfunction

  function automatic logic [31:0] build_instr();
    logic [31:0] r;
    logic [31:0] instr;
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r    = next_rand();
    kind = r % 9;
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    case (kind)
      0: instr = {fpss_pkg::FUNCT7_FSGNJ, rs2, rs1, 3'b000, rd, fpss_pkg::OPCODE_OP_FP};
      1: instr = {fpss_pkg::FUNCT7_FSGNJ, rs2, rs1, 3'b001, rd, fpss_pkg::OPCODE_OP_FP};
      2: instr = {fpss_pkg::FUNCT7_FSGNJ, rs2, rs1, 3'b010, rd, fpss_pkg::OPCODE_OP_FP};
      3, 4: instr = {fpss_pkg::FUNCT7_FMV_X_W, 5'd0, rs1, 3'b000, rd, fpss_pkg::OPCODE_OP_FP};
      5, 6: instr = {fpss_pkg::FUNCT7_FMV_W_X, 5'd0, rs1, 3'b000, rd, fpss_pkg::OPCODE_OP_FP};
      7: begin
        // Some other major opcode
        instr = next_rand();
        if (instr[6:0] == fpss_pkg::OPCODE_OP_FP) begin
          instr[6:0] = 7'b0110011;
        end
      end
      default: begin
        r     = next_rand();
        instr = {r[31:25], r[24:20], rs1, r[14:12], rd, fpss_pkg::OPCODE_OP_FP};
      end
    endcase
    return instr;
  endfunction

  // --------------------
  // Reference model
  // --------------------
  function automatic fpss_pkg::issue_resp_t expected_resp(input logic [31:0] instr);
    fpss_pkg::issue_resp_t resp;
    logic                  plain;
    resp  = '0;
    plain = (instr[14:12] == 3'b000) && (instr[24:20] == 5'd0);
    if (instr[6:0] == fpss_pkg::OPCODE_OP_FP) begin
      if (instr[31:25] == fpss_pkg::FUNCT7_FSGNJ && instr[14:12] <= 3'b010) begin
        resp.accept = 1'b1;
      end else if (instr[31:25] == fpss_pkg::FUNCT7_FMV_X_W && plain) begin
        resp.accept    = 1'b1;
        resp.writeback = 1'b1;
      end else if (instr[31:25] == fpss_pkg::FUNCT7_FMV_W_X && plain) begin
        resp.accept = 1'b1;
      end
    end
    return resp;
  endfunction

  // Applied in issue order since instructions complete in order
  task automatic apply_model(input fpss_pkg::issue_req_t req);
    fpss_pkg::issue_resp_t resp;
    fpss_pkg::result_t     res;
    logic [31:0]           a;
    logic [31:0]           b;
    resp = expected_resp(req.instr);
    a    = model_fpr[req.instr[19:15]];
    b    = model_fpr[req.instr[24:20]];
    if (resp.accept) begin
      case (req.instr[31:25])
        fpss_pkg::FUNCT7_FSGNJ: begin
          case (req.instr[14:12])
            3'b000:  model_fpr[req.instr[11:7]] = {b[31], a[30:0]};
            3'b001:  model_fpr[req.instr[11:7]] = {~b[31], a[30:0]};
            default: model_fpr[req.instr[11:7]] = {a[31] ^ b[31], a[30:0]};
          endcase
        end
        fpss_pkg::FUNCT7_FMV_X_W: begin
          res.data = a;
          res.rd   = req.instr[11:7];
          res.id   = req.id;
          exp_q.push_back(res);
        end
        default: model_fpr[req.instr[11:7]] = req.rs1_val;
      endcase
    end
  endtask

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_resp(input fpss_pkg::issue_resp_t got,
                            input fpss_pkg::issue_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: issue response accept=%b writeback=%b, expected %b/%b",
               $time, got.accept, got.writeback, exp.accept, exp.writeback);
    end
  endtask

  task automatic check_result(input fpss_pkg::result_t got, input fpss_pkg::result_t exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at time %0t: %s data=%h rd=%0d id=%0d, expected data=%h rd=%0d id=%0d",
               $time, what, got.data, got.rd, got.id, exp.data, exp.rd, exp.id);
    end
  endtask

  // Sampled at the falling edge ahead of the transfer edge
  task automatic observe();
    fpss_pkg::result_t exp_res;
    if (hold_res) begin
      if (x_result_valid_o !== 1'b1) begin
        errors++;
        $display("Error at time %0t: result valid dropped before it was accepted", $time);
      end else begin
        check_result(x_result_o, held_res, "held result changed,");
      end
    end
    hold_res = 1'b0;
    if (x_result_valid_o) begin
      if (x_result_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at time %0t: result transfer with no result expected", $time);
        end else begin
          exp_res = exp_q.pop_front();
          check_result(x_result_o, exp_res, "result");
          results++;
        end
      end else begin
        hold_res = 1'b1;
        held_res = x_result_o;
      end
    end
    hold_req = 1'b0;
    if (x_issue_valid_i) begin
      if (x_issue_ready_o) begin
        check_resp(x_issue_resp_o, expected_resp(x_issue_req_i.instr));
        apply_model(x_issue_req_i);
        issued++;
      end else begin
        hold_req = 1'b1;
      end
    end
  endtask

  task automatic drive_next();
    fpss_pkg::issue_req_t req;
    logic [31:0]          r;
    r = next_rand();
    x_result_ready_i <= (r % 10) < 7;
    if (!hold_req) begin
      if (issued >= NUM_TXN) begin
        x_issue_valid_i <= 1'b0;
      end else begin
        req.instr   = build_instr();
        req.rs1_val = next_rand();
        r           = next_rand();
        req.id      = r[3:0];
        x_issue_req_i   <= req;
        x_issue_valid_i <= (r[9:8] != 2'b00);
      end
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    rng_q    = 32'h697757aa;
    hold_res = 1'b0;
    hold_req = 1'b0;
    issued   = 0;
    results  = 0;
    checks   = 0;
    errors   = 0;
    drain    = 0;
    for (int i = 0; i < fpss_pkg::NUM_FPR; i++) begin
      model_fpr[i] = '0;
    end
    rst_n_i          <= 1'b0;
    x_issue_valid_i  <= 1'b0;
    x_issue_req_i    <= '0;
    x_result_ready_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    checks++;
    if (x_result_valid_o !== 1'b0 || x_issue_ready_o !== 1'b1) begin
      errors++;
      $display("Error at time %0t: after reset result valid=%b issue ready=%b",
               $time, x_result_valid_o, x_issue_ready_o);
    end
    while (issued < NUM_TXN) begin
      @(posedge clk_i);
      drive_next();
      @(negedge clk_i);
      observe();
    end
    // Bounded wait for the results still in flight
    while (exp_q.size() != 0 && drain < DRAIN_CYCLES) begin
      @(posedge clk_i);
      drive_next();
      @(negedge clk_i);
      observe();
      drain++;
    end
    // A few idle cycles to catch a late duplicate result
    repeat (4) begin
      @(posedge clk_i);
      drive_next();
      @(negedge clk_i);
      observe();
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected results never came back", exp_q.size());
    end
    $display("checks=%0d errors=%0d transfers=%0d results=%0d", checks, errors, issued, results);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TXN * 40 * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", NUM_TXN * 40);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* logic/fpss_top.sv */
`timescale 1ns/1ps

module fpss_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  // Issue interface
  input  logic                  x_issue_valid_i,
  output logic                  x_issue_ready_o,
  input  fpss_pkg::issue_req_t  x_issue_req_i,
  output fpss_pkg::issue_resp_t x_issue_resp_o,

  // Result interface
  output logic                  x_result_valid_o,
  input  logic                  x_result_ready_i,
  output fpss_pkg::result_t     x_result_o
);

  fpss_pkg::decoded_t              dec;
  logic [fpss_pkg::XLEN-1:0]       rdata_a;
  logic [fpss_pkg::XLEN-1:0]       rdata_b;
  logic                            fpr_we;
  logic [fpss_pkg::REG_ADDR_W-1:0] fpr_waddr;
  logic [fpss_pkg::XLEN-1:0]       fpr_wdata;
  logic                            s1_en;
  logic                            s2_en;
  logic                            s2_valid;

  // --------------------
  // Decoder
  // --------------------
  fpss_decoder u_decoder (
    .instr_i (x_issue_req_i.instr),
    .dec_o   (dec),
    .resp_o  (x_issue_resp_o)
  );

  // --------------------
  // FP register file
  // --------------------
  fpss_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .we_i      (fpr_we),
    .waddr_i   (fpr_waddr),
    .wdata_i   (fpr_wdata),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  // --------------------
  // Controller
  // --------------------
  fpss_controller u_controller (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .issue_valid_i  (x_issue_valid_i),
    .accept_i       (x_issue_resp_o.accept),
    .dec_i          (dec),
    .result_ready_i (x_result_ready_i),
    .issue_ready_o  (x_issue_ready_o),
    .s1_en_o        (s1_en),
    .s2_en_o        (s2_en),
    .s2_valid_o     (s2_valid),
    .result_valid_o (x_result_valid_o)
  );

  // Execution pipeline, integer operand comes straight from the core
  fpss_exec u_exec (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .s1_en_i     (s1_en),
    .s2_en_i     (s2_en),
    .s2_valid_i  (s2_valid),
    .dec_i       (dec),
    .id_i        (x_issue_req_i.id),
    .op_a_i      (rdata_a),
    .op_b_i      (rdata_b),
    .int_op_i    (x_issue_req_i.rs1_val),
    .fpr_we_o    (fpr_we),
    .fpr_waddr_o (fpr_waddr),
    .fpr_wdata_o (fpr_wdata),
    .result_o    (x_result_o)
  );

endmodule

/* logic/fpss_exec.sv */
`timescale 1ns/1ps

module fpss_exec (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            s1_en_i,
  input  logic                            s2_en_i,
  input  logic                            s2_valid_i,
  input  fpss_pkg::decoded_t              dec_i,
  input  logic [fpss_pkg::ID_W-1:0]       id_i,
  input  logic [fpss_pkg::XLEN-1:0]       op_a_i,
  input  logic [fpss_pkg::XLEN-1:0]       op_b_i,
  input  logic [fpss_pkg::XLEN-1:0]       int_op_i,
  output logic                            fpr_we_o,
  output logic [fpss_pkg::REG_ADDR_W-1:0] fpr_waddr_o,
  output logic [fpss_pkg::XLEN-1:0]       fpr_wdata_o,
  output fpss_pkg::result_t               result_o
);

  fpss_pkg::fp_op_e          s1_op_q;
  logic [fpss_pkg::XLEN-1:0] s1_a_q;
  logic [fpss_pkg::XLEN-1:0] s1_b_q;
  logic [fpss_pkg::XLEN-1:0] s1_int_q;
  fpss_pkg::exec_tag_t       s1_tag_q;
  logic [fpss_pkg::XLEN-1:0] s1_res;
  fpss_pkg::fp_op_e          s2_op_q;
  logic [fpss_pkg::XLEN-1:0] s2_data_q;
  fpss_pkg::exec_tag_t       s2_tag_q;

  // Stage one
  always_ff @(posedge clk_i) begin
    if (s1_en_i) begin
      s1_op_q           <= dec_i.op;
      s1_a_q            <= op_a_i;
      s1_b_q            <= op_b_i;
      s1_int_q          <= int_op_i;
      s1_tag_q.rd       <= dec_i.rd;
      s1_tag_q.rd_is_fp <= dec_i.rd_is_fp;
      s1_tag_q.id       <= id_i;
    end
  end

  // Magnitude from rs1 with the sign picked per variant
  always_comb begin
    case (s1_op_q)
      fpss_pkg::OP_SGNJ:   s1_res = {s1_b_q[31], s1_a_q[30:0]};
      fpss_pkg::OP_SGNJN:  s1_res = {~s1_b_q[31], s1_a_q[30:0]};
      fpss_pkg::OP_SGNJX:  s1_res = {s1_a_q[31] ^ s1_b_q[31], s1_a_q[30:0]};
      fpss_pkg::OP_MV_X_W: s1_res = s1_a_q;
      default:             s1_res = s1_int_q;
    endcase
  end

  // Stage two holds while the core back-pressures
  always_ff @(posedge clk_i) begin
    if (s2_en_i) begin
      s2_op_q   <= s1_op_q;
      s2_data_q <= s1_res;
      s2_tag_q  <= s1_tag_q;
    end
  end

  assign fpr_we_o    = s2_valid_i && s2_tag_q.rd_is_fp;
  assign fpr_waddr_o = s2_tag_q.rd;
  assign fpr_wdata_o = s2_data_q;

  assign result_o.data = s2_data_q;
  assign result_o.rd   = s2_tag_q.rd;
  assign result_o.id   = s2_tag_q.id;

  // An fmv.x.w in stage two never reaches the FP register file
  a_one_sink: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(fpr_we_o && (s2_op_q == fpss_pkg::OP_MV_X_W))
  );

endmodule

/* logic/fpss_controller.sv */
`timescale 1ns/1ps

module fpss_controller (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               issue_valid_i,
  input  logic               accept_i,
  input  fpss_pkg::decoded_t dec_i,
  input  logic               result_ready_i,
  output logic               issue_ready_o,
  output logic               s1_en_o,
  output logic               s2_en_o,
  output logic               s2_valid_o,
  output logic               result_valid_o
);

  logic                            s1_valid_q;
  logic                            s1_rd_fp_q;
  logic [fpss_pkg::REG_ADDR_W-1:0] s1_rd_q;
  logic                            s2_valid_q;
  logic                            s2_rd_fp_q;

  logic out_stall;
  logic raw_rs1;
  logic raw_rs2;
  logic hazard;
  logic issue_fire;

  // --------------------
  // Stall and enables
  // --------------------
  // Core not taking the result freezes both stages
  assign out_stall = result_valid_o && !result_ready_i;
  assign s1_en_o   = !out_stall;
  assign s2_en_o   = !out_stall;

  // RAW against stage one, its result is not in the register file yet
  assign raw_rs1 = dec_i.rs1_is_fp && (dec_i.rs1 == s1_rd_q);
  assign raw_rs2 = dec_i.rs2_used && (dec_i.rs2 == s1_rd_q);
  assign hazard  = s1_valid_q && s1_rd_fp_q && (raw_rs1 || raw_rs2);

  assign issue_ready_o = !out_stall && !hazard;
  assign issue_fire    = issue_valid_i && issue_ready_o && accept_i;

  // --------------------
  // Stage valids
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s1_rd_fp_q <= 1'b0;
      s2_valid_q <= 1'b0;
      s2_rd_fp_q <= 1'b0;
    end else begin
      if (s1_en_o) begin
        s1_valid_q <= issue_fire;
        s1_rd_fp_q <= dec_i.rd_is_fp;
      end
      if (s2_en_o) begin
        s2_valid_q <= s1_valid_q;
        s2_rd_fp_q <= s1_rd_fp_q;
      end
    end
  end

  // Pending destination, qualified by s1_valid_q
  always_ff @(posedge clk_i) begin
    if (s1_en_o) begin
      s1_rd_q <= dec_i.rd;
    end
  end

  assign s2_valid_o     = s2_valid_q;
  assign result_valid_o = s2_valid_q && !s2_rd_fp_q;

  a_result_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    result_valid_o && !result_ready_i |=> result_valid_o
  );

endmodule

/* logic/fpss_regfile.sv */
`timescale 1ns/1ps

module fpss_regfile (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [fpss_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [fpss_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic                            we_i,
  input  logic [fpss_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [fpss_pkg::XLEN-1:0]       wdata_i,
  output logic [fpss_pkg::XLEN-1:0]       rdata_a_o,
  output logic [fpss_pkg::XLEN-1:0]       rdata_b_o
);

  logic [fpss_pkg::XLEN-1:0] regs_q [fpss_pkg::NUM_FPR];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < fpss_pkg::NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Write-through so an issuing instruction sees the retiring write
  always_comb begin
    rdata_a_o = regs_q[raddr_a_i];
    rdata_b_o = regs_q[raddr_b_i];
    if (we_i && (waddr_i == raddr_a_i)) begin
      rdata_a_o = wdata_i;
    end
    if (we_i && (waddr_i == raddr_b_i)) begin
      rdata_b_o = wdata_i;
    end
  end

  a_waddr_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> !$isunknown(waddr_i)
  );

endmodule

/* logic/fpss_decoder.sv */
`timescale 1ns/1ps

module fpss_decoder (
  input  logic [fpss_pkg::XLEN-1:0] instr_i,
  output fpss_pkg::decoded_t        dec_o,
  output fpss_pkg::issue_resp_t     resp_o
);

  logic [6:0]                      opcode;
  logic [6:0]                      funct7;
  logic [2:0]                      funct3;
  logic [fpss_pkg::REG_ADDR_W-1:0] rs2_field;
  logic                            accept;

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign rs2_field = instr_i[24:20];
  assign funct7    = instr_i[31:25];

  always_comb begin
    accept          = 1'b0;
    dec_o.op        = fpss_pkg::OP_SGNJ;
    dec_o.rs1       = instr_i[19:15];
    dec_o.rs2       = rs2_field;
    dec_o.rd        = instr_i[11:7];
    dec_o.rd_is_fp  = 1'b0;
    dec_o.rs1_is_fp = 1'b0;
    dec_o.rs2_used  = 1'b0;

    if (opcode == fpss_pkg::OPCODE_OP_FP) begin
      case (funct7)
        fpss_pkg::FUNCT7_FSGNJ: begin
          // Sign injection variant picked by funct3
          case (funct3)
            3'b000: begin
              accept   = 1'b1;
              dec_o.op = fpss_pkg::OP_SGNJ;
            end
            3'b001: begin
              accept   = 1'b1;
              dec_o.op = fpss_pkg::OP_SGNJN;
            end
            3'b010: begin
              accept   = 1'b1;
              dec_o.op = fpss_pkg::OP_SGNJX;
            end
            default: ;
          endcase
          dec_o.rd_is_fp  = accept;
          dec_o.rs1_is_fp = accept;
          dec_o.rs2_used  = accept;
        end
        fpss_pkg::FUNCT7_FMV_X_W: begin
          // FP source, integer destination
          if (funct3 == 3'b000 && rs2_field == '0) begin
            accept          = 1'b1;
            dec_o.op        = fpss_pkg::OP_MV_X_W;
            dec_o.rs1_is_fp = 1'b1;
          end
        end
        fpss_pkg::FUNCT7_FMV_W_X: begin
          // Integer operand from the core, FP destination
          if (funct3 == 3'b000 && rs2_field == '0) begin
            accept         = 1'b1;
            dec_o.op       = fpss_pkg::OP_MV_W_X;
            dec_o.rd_is_fp = 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Only fmv.x.w hands a value back to the integer side
  assign resp_o.accept    = accept;
  assign resp_o.writeback = accept && (dec_o.op == fpss_pkg::OP_MV_X_W);

endmodule

/* logic/fpss_pkg.sv */
package fpss_pkg;

  // --------------------
  // Widths and sizes
  // --------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned NUM_FPR    = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned ID_W       = 4;

  // --------------------
  // Encodings
  // --------------------
  localparam logic [6:0] OPCODE_OP_FP   = 7'b1010011;
  // fsgnj.s, fsgnjn.s and fsgnjx.s share funct7, split by funct3
  localparam logic [6:0] FUNCT7_FSGNJ   = 7'b0010000;
  localparam logic [6:0] FUNCT7_FMV_X_W = 7'b1110000;
  localparam logic [6:0] FUNCT7_FMV_W_X = 7'b1111000;

  // Decoded operation
  typedef enum logic [2:0] {
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX,
    OP_MV_X_W,
    OP_MV_W_X
  } fp_op_e;

  // --------------------
  // Interface structs
  // --------------------
  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1_val;
    logic [ID_W-1:0] id;
  } issue_req_t;

  typedef struct packed {
    logic accept;
    logic writeback;
  } issue_resp_t;

  typedef struct packed {
    logic [XLEN-1:0]       data;
    logic [REG_ADDR_W-1:0] rd;
    logic [ID_W-1:0]       id;
  } result_t;

  // Internal structs
  typedef struct packed {
    fp_op_e                op;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_is_fp;
    logic                  rs1_is_fp;
    logic                  rs2_used;
  } decoded_t;

  // Destination info carried alongside the data
  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_is_fp;
    logic [ID_W-1:0]       id;
  } exec_tag_t;

endpackage
